// ==== filelist.f ====
rtl/pulp_pkg.sv
rtl/l2_mem.sv
rtl/l2_atomics.sv
rtl/atop_filter.sv
rtl/soc_bus.sv
rtl/pulp_soc.sv
tests/pulp_soc_chk.sv
tests/soc_checker.sv
tests/tb_pulp_soc.sv

// ==== Bender.yml ====
package:
  name: pulp_soc

sources:
  - rtl/pulp_pkg.sv
  - rtl/l2_mem.sv
  - rtl/l2_atomics.sv
  - rtl/atop_filter.sv
  - rtl/soc_bus.sv
  - rtl/pulp_soc.sv
  - target: test
    files:
      - tests/pulp_soc_chk.sv
      - tests/soc_checker.sv
      - tests/tb_pulp_soc.sv

// ==== tests/tb_pulp_soc.sv ====
module tb_pulp_soc;
  import pulp_pkg::*;

  localparam int unsigned N_CLUSTERS  = 2;
  localparam int unsigned CL_CREDITS  = 2;
  localparam int unsigned EXT_CREDITS = 4;
  localparam int unsigned N_TAGS      = 2 ** TAG_W;
  localparam logic [DATA_W-1:0] EXT_KEY = 32'h5A3C_96E1;
  // requests per cluster
  localparam int unsigned N_REQ        = 300;
  localparam int unsigned RUN_CYCLES   = 30000;
  localparam int unsigned DRAIN_CYCLES = 2000;

  logic                       clk_i;
  logic                       rst_n_i;
  logic    [N_CLUSTERS-1:0]   cl_req_valid_i;
  cl_req_t [N_CLUSTERS-1:0]   cl_req_i;
  logic    [N_CLUSTERS-1:0]   cl_credit_o;
  logic    [N_CLUSTERS-1:0]   cl_rsp_valid_o;
  cl_rsp_t [N_CLUSTERS-1:0]   cl_rsp_o;
  logic                       ext_req_valid_o;
  sb_req_t                    ext_req_o;
  logic                       ext_credit_i;
  logic                       ext_rsp_valid_i;
  sb_rsp_t                    ext_rsp_i;

  int                         credits [N_CLUSTERS];
  int unsigned                issued [N_CLUSTERS];
  logic [N_TAGS-1:0]          tag_busy [N_CLUSTERS];
  logic                       l2_written [L2_WORDS];
  int unsigned                cycle;
  int unsigned                crd_delay_max;
  sb_req_t                    ext_pend [$];
  int unsigned                crd_due [$];
  int unsigned                total_errs;

  pulp_soc #(
    .N_CLUSTERS  (N_CLUSTERS),
    .CL_CREDITS  (CL_CREDITS),
    .EXT_CREDITS (EXT_CREDITS)
  ) u_dut (.*);

  soc_checker #(
    .N_CLUSTERS (N_CLUSTERS),
    .CL_CREDITS (CL_CREDITS),
    .EXT_KEY    (EXT_KEY)
  ) u_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int free_tag(input int c);
    for (int t = 0; t < N_TAGS; t++) begin
      if (!tag_busy[c][t]) return t;
    end
    return -1;
  endfunction

  function automatic int unsigned outstanding();
    int unsigned n;
    n = 0;
    for (int c = 0; c < N_CLUSTERS; c++) begin
      n += $countones(tag_busy[c]);
    end
    return n;
  endfunction

  function automatic bit all_idle();
    bit idle;
    idle = (outstanding() == 0) && (ext_pend.size() == 0) && (crd_due.size() == 0);
    for (int c = 0; c < N_CLUSTERS; c++) begin
      idle &= (credits[c] == int'(CL_CREDITS));
    end
    return idle;
  endfunction

  function automatic bit issue_done();
    bit done;
    done = 1'b1;
    for (int c = 0; c < N_CLUSTERS; c++) begin
      done &= (issued[c] >= N_REQ);
    end
    return done;
  endfunction

  // outputs as they stood before the edge
  task automatic sample_outputs();
    for (int c = 0; c < N_CLUSTERS; c++) begin
      if (cl_credit_o[c]) credits[c]++;
      if (cl_rsp_valid_o[c]) tag_busy[c][cl_rsp_o[c].tag] = 1'b0;
    end
    if (ext_req_valid_o) begin
      ext_pend.push_back(ext_req_o);
      crd_due.push_back(cycle + 1 + $urandom % crd_delay_max);
    end
  endtask

  // external target, one credit pulse and one response per cycle at most
  task automatic drive_target();
    int      idx;
    sb_req_t req;
    sb_rsp_t rsp;
    ext_credit_i    = 1'b0;
    ext_rsp_valid_i = 1'b0;
    idx = -1;
    for (int i = 0; i < crd_due.size(); i++) begin
      if (idx < 0 && crd_due[i] <= cycle) idx = i;
    end
    if (idx >= 0) begin
      ext_credit_i = 1'b1;
      crd_due.delete(idx);
    end
    if (ext_pend.size() != 0 && $urandom % 2 == 0) begin
      req       = ext_pend.pop_front();
      rsp.rdata = req.we ? '0 : req.addr ^ EXT_KEY;
      rsp.err   = 1'b0;
      rsp.id    = req.id;
      ext_rsp_valid_i = 1'b1;
      ext_rsp_i       = rsp;
    end
  endtask

  task automatic drive_cluster(input int c, input bit allow);
    int          t;
    int unsigned kind;
    int unsigned word;
    cl_req_t     req;
    cl_req_valid_i[c] = 1'b0;
    t = free_tag(c);
    if (!allow || credits[c] == 0 || t < 0 || $urandom % 4 == 0) return;
    req       = '0;
    req.tag   = TAG_W'(t);
    req.wdata = $urandom;
    kind      = $urandom % 10;
    if (kind < 6) begin
      // each cluster owns one half of L2
      word     = c * (L2_WORDS / N_CLUSTERS) + $urandom % (L2_WORDS / N_CLUSTERS);
      req.addr = L2_BASE + ADDR_W'(word * 4);
      if (!l2_written[word] || kind < 2) begin
        req.we           = 1'b1;
        l2_written[word] = 1'b1;
      end else if (kind < 4) begin
        req.amo = 1'b1;
      end
    end else begin
      req.addr = 32'h4000_0000 + ADDR_W'(($urandom % 1024) * 4);
      req.we   = (kind == 7);
      req.amo  = (kind == 9);
    end
    cl_req_valid_i[c] = 1'b1;
    cl_req_i[c]       = req;
    tag_busy[c][t]    = 1'b1;
    credits[c]--;
    issued[c]++;
  endtask

  task automatic step(input bit allow);
    @(posedge clk_i);
    sample_outputs();
    #1;
    drive_target();
    for (int c = 0; c < N_CLUSTERS; c++) begin
      drive_cluster(c, allow && issued[c] < N_REQ);
    end
    cycle++;
  endtask

  initial begin
    int unsigned run_cnt;
    int unsigned wait_cnt;
    void'($urandom(14));
    rst_n_i         = 1'b0;
    cl_req_valid_i  = '0;
    cl_req_i        = '0;
    ext_credit_i    = 1'b0;
    ext_rsp_valid_i = 1'b0;
    ext_rsp_i       = '0;
    cycle           = 0;
    crd_delay_max   = 4;
    for (int c = 0; c < N_CLUSTERS; c++) begin
      credits[c]  = CL_CREDITS;
      issued[c]   = 0;
      tag_busy[c] = '0;
    end
    for (int w = 0; w < L2_WORDS; w++) begin
      l2_written[w] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    #1 rst_n_i = 1'b1;

    run_cnt = 0;
    while (!issue_done() && run_cnt < RUN_CYCLES) begin
      step(1'b1);
      run_cnt++;
      // second half runs with a slow external target
      if (issued[0] + issued[1] >= N_REQ) crd_delay_max = 16;
    end

    if (!issue_done()) begin
      $display("timeout: clusters stopped taking requests, %0d outstanding", outstanding());
      $display("Checks failed");
      $finish;
    end else begin
      wait_cnt = 0;
      while (!all_idle() && wait_cnt < DRAIN_CYCLES) begin
        step(1'b0);
        wait_cnt++;
      end
      if (!all_idle()) begin
        $display("timeout: drain incomplete, %0d requests outstanding", outstanding());
        $display("Checks failed");
        $finish;
      end else begin
        u_checker.check_drained();
        total_errs = u_checker.value_errs + u_checker.proto_errs + u_dut.u_chk.fail_cnt;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 u_checker.value_errs, u_checker.proto_errs, u_dut.u_chk.fail_cnt);
        if (total_errs == 0) begin
          $display("All checks passed");
        end else begin
          $display("Checks failed");
        end
        $finish;
      end
    end
  end

endmodule

// ==== tests/soc_checker.sv ====
module soc_checker #(
  parameter int unsigned                  N_CLUSTERS = 2,
  parameter int unsigned                  CL_CREDITS = 2,
  parameter logic [pulp_pkg::DATA_W-1:0] EXT_KEY    = '0
) (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic              [N_CLUSTERS-1:0] cl_req_valid_i,
  input pulp_pkg::cl_req_t [N_CLUSTERS-1:0] cl_req_i,
  input logic              [N_CLUSTERS-1:0] cl_credit_o,
  input logic              [N_CLUSTERS-1:0] cl_rsp_valid_o,
  input pulp_pkg::cl_rsp_t [N_CLUSTERS-1:0] cl_rsp_o,
  input logic                               ext_req_valid_o,
  input pulp_pkg::sb_req_t                  ext_req_o
);
  import pulp_pkg::*;

  localparam int unsigned N_TAGS = 2 ** TAG_W;

  logic [DATA_W-1:0] shadow [L2_WORDS];
  logic              pend [N_CLUSTERS][N_TAGS];
  // still expected on the external port
  logic              fwd [N_CLUSTERS][N_TAGS];
  logic [DATA_W-1:0] exp_data [N_CLUSTERS][N_TAGS];
  logic              exp_err [N_CLUSTERS][N_TAGS];
  logic [ADDR_W-1:0] exp_addr [N_CLUSTERS][N_TAGS];
  logic [DATA_W-1:0] exp_wdata [N_CLUSTERS][N_TAGS];
  logic              exp_we [N_CLUSTERS][N_TAGS];
  int                occ [N_CLUSTERS];
  int                n_req [N_CLUSTERS];
  int                n_crd [N_CLUSTERS];
  int                n_rsp [N_CLUSTERS];
  int                value_errs = 0;
  int                proto_errs = 0;

  initial begin
    for (int c = 0; c < N_CLUSTERS; c++) begin
      occ[c]   = 0;
      n_req[c] = 0;
      n_crd[c] = 0;
      n_rsp[c] = 0;
      for (int t = 0; t < N_TAGS; t++) begin
        pend[c][t] = 1'b0;
        fwd[c][t]  = 1'b0;
      end
    end
  end

  // expected response computed in issue order per cluster
  task automatic predict(input int c, input cl_req_t req);
    logic        in_l2;
    int unsigned word;
    in_l2 = (req.addr >= L2_BASE) && (req.addr < L2_BASE + L2_WORDS * 4);
    word  = req.addr[L2_IDX_W+1:2];
    if (pend[c][req.tag]) begin
      proto_errs++;
      $display("cluster %0d reused tag %0d while still outstanding", c, req.tag);
    end
    pend[c][req.tag]      = 1'b1;
    fwd[c][req.tag]       = 1'b0;
    exp_err[c][req.tag]   = 1'b0;
    exp_addr[c][req.tag]  = req.addr;
    exp_wdata[c][req.tag] = req.wdata;
    exp_we[c][req.tag]    = req.we;
    if (in_l2 && req.amo) begin
      exp_data[c][req.tag] = shadow[word];
      shadow[word]         = shadow[word] + req.wdata;
    end else if (in_l2 && req.we) begin
      exp_data[c][req.tag] = '0;
      shadow[word]         = req.wdata;
    end else if (in_l2) begin
      exp_data[c][req.tag] = shadow[word];
    end else if (req.amo) begin
      exp_data[c][req.tag] = '0;
      exp_err[c][req.tag]  = 1'b1;
    end else begin
      exp_data[c][req.tag] = req.we ? '0 : req.addr ^ EXT_KEY;
      fwd[c][req.tag]      = 1'b1;
    end
  endtask

  task automatic check_rsp(input int c, input cl_rsp_t rsp);
    if (!pend[c][rsp.tag]) begin
      proto_errs++;
      $display("cluster %0d got a response with unknown tag %0d at time %0t", c, rsp.tag, $time);
    end else begin
      if (rsp.rdata !== exp_data[c][rsp.tag] || rsp.err !== exp_err[c][rsp.tag]) begin
        value_errs++;
        $display("Fail %0t: cluster %0d tag %0d got rdata %h err %b, expected %h err %b",
                 $time, c, rsp.tag, rsp.rdata, rsp.err, exp_data[c][rsp.tag],
                 exp_err[c][rsp.tag]);
      end
      if (fwd[c][rsp.tag]) begin
        proto_errs++;
        $display("cluster %0d tag %0d answered before reaching the external port", c, rsp.tag);
      end
      pend[c][rsp.tag] = 1'b0;
      n_rsp[c]++;
    end
  endtask

  // cluster index must sit in the upper id bit
  task automatic check_ext(input sb_req_t req);
    int c;
    int t;
    c = req.id[ID_W-1 -: CL_IDX_W];
    t = req.id[TAG_W-1:0];
    if (!pend[c][t] || !fwd[c][t]) begin
      proto_errs++;
      $display("unexpected request on the external port, id %h, at time %0t", req.id, $time);
    end else begin
      if (req.addr !== exp_addr[c][t] || req.wdata !== exp_wdata[c][t] ||
          req.we !== exp_we[c][t] || req.amo !== 1'b0) begin
        value_errs++;
        $display("Fail %0t: external id %h sent addr %h wdata %h we %b amo %b, %s",
                 $time, req.id, req.addr, req.wdata, req.we, req.amo,
                 $sformatf("expected addr %h wdata %h we %b amo 0",
                           exp_addr[c][t], exp_wdata[c][t], exp_we[c][t]));
      end
      fwd[c][t] = 1'b0;
    end
  endtask

  task automatic check_drained();
    for (int c = 0; c < N_CLUSTERS; c++) begin
      if (n_req[c] != n_crd[c] || n_req[c] != n_rsp[c]) begin
        proto_errs++;
        $display("cluster %0d: %0d requests but %0d credits and %0d responses",
                 c, n_req[c], n_crd[c], n_rsp[c]);
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      for (int c = 0; c < N_CLUSTERS; c++) begin
        if (cl_rsp_valid_o[c]) begin
          check_rsp(c, cl_rsp_o[c]);
        end
        if (cl_credit_o[c]) begin
          if (occ[c] == 0) begin
            proto_errs++;
            $display("cluster %0d got a credit with an empty FIFO at time %0t", c, $time);
          end
          occ[c]--;
          n_crd[c]++;
        end
        if (cl_req_valid_i[c]) begin
          predict(c, cl_req_i[c]);
          occ[c]++;
          n_req[c]++;
        end
        if (occ[c] > int'(CL_CREDITS)) begin
          proto_errs++;
          $display("cluster %0d has more requests outstanding than credits", c);
        end
      end
      if (ext_req_valid_o) begin
        check_ext(ext_req_o);
      end
    end
  end

endmodule

// ==== tests/pulp_soc_chk.sv ====
module pulp_soc_chk #(
  parameter int unsigned N_CLUSTERS  = 2,
  parameter int unsigned EXT_CREDITS = 4
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic [N_CLUSTERS-1:0] cl_req_valid_i,
  input logic [N_CLUSTERS-1:0] cl_credit_o,
  input logic [N_CLUSTERS-1:0] cl_rsp_valid_o,
  input logic                  ext_req_valid_o,
  input logic                  ext_credit_i
);

  int unsigned fail_cnt = 0;
  int unsigned ext_crd;

  // credits held by the filter, as seen from its port
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ext_crd <= EXT_CREDITS;
    end else begin
      ext_crd <= ext_crd - 32'(ext_req_valid_o) + 32'(ext_credit_i);
    end
  end

  ext_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_req_valid_o |-> ext_crd != 0)
  else begin
    $error("external request sent with no credit left");
    fail_cnt++;
  end

  // first edge of reset still sees unreset state
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i && $past(!rst_n_i) |-> (cl_rsp_valid_o == '0) && !ext_req_valid_o)
  else begin
    $error("response or external request valid during reset");
    fail_cnt++;
  end

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_cl
    int unsigned occ;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        occ <= 0;
      end else begin
        occ <= occ + 32'(cl_req_valid_i[i]) - 32'(cl_credit_o[i]);
      end
    end

    credit_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cl_credit_o[i] |-> occ != 0)
    else begin
      $error("credit returned to cluster %0d with no request pending", i);
      fail_cnt++;
    end
  end

endmodule

bind pulp_soc pulp_soc_chk #(
  .N_CLUSTERS  (N_CLUSTERS),
  .EXT_CREDITS (EXT_CREDITS)
) u_chk (.*);

// ==== rtl/pulp_soc.sv ====
module pulp_soc #(
  parameter int unsigned N_CLUSTERS  = 2,
  parameter int unsigned CL_CREDITS  = 2,
  parameter int unsigned EXT_CREDITS = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic              [N_CLUSTERS-1:0] cl_req_valid_i,
  input  pulp_pkg::cl_req_t [N_CLUSTERS-1:0] cl_req_i,
  output logic              [N_CLUSTERS-1:0] cl_credit_o,
  output logic              [N_CLUSTERS-1:0] cl_rsp_valid_o,
  output pulp_pkg::cl_rsp_t [N_CLUSTERS-1:0] cl_rsp_o,
  output logic                               ext_req_valid_o,
  output pulp_pkg::sb_req_t                  ext_req_o,
  input  logic                               ext_credit_i,
  input  logic                               ext_rsp_valid_i,
  input  pulp_pkg::sb_rsp_t                  ext_rsp_i
);
  import pulp_pkg::*;

  // bus to L2 atomics
  logic    l2_req_valid;
  logic    l2_req_ready;
  sb_req_t l2_req;
  logic    l2_rsp_valid;
  logic    l2_rsp_ready;
  sb_rsp_t l2_rsp;

  // bus to atomic filter
  logic    xf_req_valid;
  logic    xf_req_ready;
  sb_req_t xf_req;
  logic    xf_rsp_valid;
  sb_rsp_t xf_rsp;

  logic              mem_en;
  logic              mem_we;
  l2_addr_t          mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;

  soc_bus #(
    .N_CLUSTERS (N_CLUSTERS),
    .CL_CREDITS (CL_CREDITS)
  ) u_soc_bus (
    .clk_i,
    .rst_n_i,
    .cl_req_valid_i,
    .cl_req_i,
    .cl_credit_o,
    .cl_rsp_valid_o,
    .cl_rsp_o,
    .l2_req_valid_o (l2_req_valid),
    .l2_req_ready_i (l2_req_ready),
    .l2_req_o       (l2_req),
    .l2_rsp_valid_i (l2_rsp_valid),
    .l2_rsp_ready_o (l2_rsp_ready),
    .l2_rsp_i       (l2_rsp),
    .xf_req_valid_o (xf_req_valid),
    .xf_req_ready_i (xf_req_ready),
    .xf_req_o       (xf_req),
    .xf_rsp_valid_i (xf_rsp_valid),
    .xf_rsp_i       (xf_rsp)
  );

  l2_atomics u_l2_atomics (
    .clk_i,
    .rst_n_i,
    .req_valid_i (l2_req_valid),
    .req_ready_o (l2_req_ready),
    .req_i       (l2_req),
    .rsp_valid_o (l2_rsp_valid),
    .rsp_ready_i (l2_rsp_ready),
    .rsp_o       (l2_rsp),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  l2_mem u_l2_mem (
    .clk_i,
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  atop_filter #(
    .EXT_CREDITS (EXT_CREDITS)
  ) u_atop_filter (
    .clk_i,
    .rst_n_i,
    .slv_req_valid_i (xf_req_valid),
    .slv_req_ready_o (xf_req_ready),
    .slv_req_i       (xf_req),
    .slv_rsp_valid_o (xf_rsp_valid),
    .slv_rsp_o       (xf_rsp),
    .ext_req_valid_o,
    .ext_req_o,
    .ext_credit_i,
    .ext_rsp_valid_i,
    .ext_rsp_i
  );

endmodule

// ==== rtl/soc_bus.sv ====
module soc_bus #(
  parameter int unsigned N_CLUSTERS = 2,
  parameter int unsigned CL_CREDITS = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic              [N_CLUSTERS-1:0]   cl_req_valid_i,
  input  pulp_pkg::cl_req_t [N_CLUSTERS-1:0]   cl_req_i,
  output logic              [N_CLUSTERS-1:0]   cl_credit_o,
  output logic              [N_CLUSTERS-1:0]   cl_rsp_valid_o,
  output pulp_pkg::cl_rsp_t [N_CLUSTERS-1:0]   cl_rsp_o,
  output logic                                 l2_req_valid_o,
  input  logic                                 l2_req_ready_i,
  output pulp_pkg::sb_req_t                    l2_req_o,
  input  logic                                 l2_rsp_valid_i,
  output logic                                 l2_rsp_ready_o,
  input  pulp_pkg::sb_rsp_t                    l2_rsp_i,
  output logic                                 xf_req_valid_o,
  input  logic                                 xf_req_ready_i,
  output pulp_pkg::sb_req_t                    xf_req_o,
  input  logic                                 xf_rsp_valid_i,
  input  pulp_pkg::sb_rsp_t                    xf_rsp_i
);
  import pulp_pkg::*;

  localparam int unsigned PTR_W = (CL_CREDITS > 1) ? $clog2(CL_CREDITS) : 1;
  localparam int unsigned CNT_W = $clog2(CL_CREDITS + 1);
  localparam int unsigned IDX_W = (N_CLUSTERS > 1) ? $clog2(N_CLUSTERS) : 1;
  localparam logic [ADDR_W-1:0] L2_END = L2_BASE + ADDR_W'(L2_WORDS * 4);

  cl_req_t [N_CLUSTERS-1:0] head;
  cl_req_t                  sel;
  sb_req_t                  out_req;
  logic [N_CLUSTERS-1:0]    head_valid;
  logic [N_CLUSTERS-1:0]    head_l2;
  logic [N_CLUSTERS-1:0]    eligible;
  logic [N_CLUSTERS-1:0]    grant;
  logic [IDX_W-1:0]         rr_q;
  logic [IDX_W-1:0]         gnt_idx;
  logic                     gnt_any;
  logic [CL_IDX_W-1:0]      l2_cl;
  logic [CL_IDX_W-1:0]      xf_cl;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(CL_CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  function automatic logic is_l2(input logic [ADDR_W-1:0] addr);
    return (addr >= L2_BASE) && (addr < L2_END);
  endfunction

  function automatic cl_rsp_t strip_id(input sb_rsp_t rsp);
    cl_rsp_t res;
    res.rdata = rsp.rdata;
    res.err   = rsp.err;
    res.tag   = rsp.id[TAG_W-1:0];
    return res;
  endfunction

  // cluster index sits in the upper id bits
  assign l2_cl = l2_rsp_i.id[ID_W-1 -: CL_IDX_W];
  assign xf_cl = xf_rsp_i.id[ID_W-1 -: CL_IDX_W];

  // external response wins when both target the same cluster
  assign l2_rsp_ready_o = !(xf_rsp_valid_i && (xf_cl == l2_cl));

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_cluster
    cl_req_t          mem_q [CL_CREDITS];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             take_xf;
    logic             take_l2;

    // credits guarantee there is always room on a push
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (cl_req_valid_i[i]) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (grant[i]) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        cnt_q <= cnt_q + CNT_W'(cl_req_valid_i[i]) - CNT_W'(grant[i]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (cl_req_valid_i[i]) begin
        mem_q[wr_ptr_q] <= cl_req_i[i];
      end
    end

    assign head[i]       = mem_q[rd_ptr_q];
    assign head_valid[i] = (cnt_q != '0);
    assign head_l2[i]    = is_l2(head[i].addr);
    assign eligible[i]   = head_valid[i] && (head_l2[i] ? l2_req_ready_i : xf_req_ready_i);

    // response steering back to this cluster
    assign take_xf = xf_rsp_valid_i && (xf_cl == CL_IDX_W'(i));
    assign take_l2 = l2_rsp_valid_i && l2_rsp_ready_o && (l2_cl == CL_IDX_W'(i));
    assign cl_rsp_valid_o[i] = take_xf || take_l2;
    assign cl_rsp_o[i]       = take_xf ? strip_id(xf_rsp_i) : strip_id(l2_rsp_i);
  end

  // round robin, search starts after the last winner
  always_comb begin
    int unsigned idx;
    gnt_idx = rr_q;
    gnt_any = 1'b0;
    grant   = '0;
    for (int unsigned k = 1; k <= N_CLUSTERS; k++) begin
      idx = (rr_q + k) % N_CLUSTERS;
      if (!gnt_any && eligible[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = IDX_W'(idx);
      end
    end
    grant[gnt_idx] = gnt_any;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= IDX_W'(N_CLUSTERS - 1);
    end else if (gnt_any) begin
      rr_q <= gnt_idx;
    end
  end

  assign sel = head[gnt_idx];

  always_comb begin
    out_req.addr  = sel.addr;
    out_req.wdata = sel.wdata;
    out_req.we    = sel.we;
    out_req.amo   = sel.amo;
    out_req.id    = {CL_IDX_W'(gnt_idx), sel.tag};
  end

  assign l2_req_o       = out_req;
  assign xf_req_o       = out_req;
  assign l2_req_valid_o = gnt_any && head_l2[gnt_idx];
  assign xf_req_valid_o = gnt_any && !head_l2[gnt_idx];

  // credit goes back in the grant cycle
  assign cl_credit_o = grant;

endmodule

// ==== rtl/atop_filter.sv ====
module atop_filter #(
  parameter int unsigned EXT_CREDITS = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              slv_req_valid_i,
  output logic              slv_req_ready_o,
  input  pulp_pkg::sb_req_t slv_req_i,
  output logic              slv_rsp_valid_o,
  output pulp_pkg::sb_rsp_t slv_rsp_o,
  output logic              ext_req_valid_o,
  output pulp_pkg::sb_req_t ext_req_o,
  input  logic              ext_credit_i,
  input  logic              ext_rsp_valid_i,
  input  pulp_pkg::sb_rsp_t ext_rsp_i
);
  import pulp_pkg::*;

  localparam int unsigned CRD_W = $clog2(EXT_CREDITS + 1);

  logic [CRD_W-1:0] credit_q;
  logic             accept;
  logic             fwd;
  logic             err_q;
  logic [ID_W-1:0]  err_id_q;
  logic             ext_valid_q;
  sb_req_t          ext_req_q;

  // a pending error blocks new requests only while an ext response takes the port
  assign slv_req_ready_o = (credit_q != '0) && !(err_q && ext_rsp_valid_i);
  assign accept          = slv_req_valid_i && slv_req_ready_o;
  assign fwd             = accept && !slv_req_i.amo;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q    <= CRD_W'(EXT_CREDITS);
      ext_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      credit_q    <= credit_q - CRD_W'(fwd) + CRD_W'(ext_credit_i);
      ext_valid_q <= fwd;
      if (accept && slv_req_i.amo) begin
        err_q <= 1'b1;
      end else if (!ext_rsp_valid_i) begin
        err_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd) begin
      ext_req_q <= slv_req_i;
    end
    if (accept && slv_req_i.amo) begin
      err_id_q <= slv_req_i.id;
    end
  end

  assign ext_req_valid_o = ext_valid_q;
  assign ext_req_o       = ext_req_q;

  // target responses go straight through, errors fill the gaps
  assign slv_rsp_valid_o = ext_rsp_valid_i || err_q;

  always_comb begin
    if (ext_rsp_valid_i) begin
      slv_rsp_o = ext_rsp_i;
    end else begin
      slv_rsp_o.rdata = '0;
      slv_rsp_o.err   = 1'b1;
      slv_rsp_o.id    = err_id_q;
    end
  end

endmodule

// ==== rtl/l2_atomics.sv ====
module l2_atomics (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  pulp_pkg::sb_req_t  req_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output pulp_pkg::sb_rsp_t  rsp_o,
  output logic               mem_en_o,
  output logic               mem_we_o,
  output pulp_pkg::l2_addr_t mem_addr_o,
  output logic [pulp_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic [pulp_pkg::DATA_W-1:0] mem_rdata_i
);
  import pulp_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_MODIFY,
    ST_RESP
  } state_e;

  state_e  state_q;
  state_e  state_d;
  sb_req_t req_q;
  logic    plain_wr;

  assign req_ready_o = (state_q == ST_IDLE);
  assign plain_wr    = req_q.we && !req_q.amo;
  assign mem_addr_o  = req_q.addr[L2_IDX_W+1:2];

  always_comb begin
    state_d     = state_q;
    mem_en_o    = 1'b0;
    mem_we_o    = 1'b0;
    mem_wdata_o = req_q.wdata;
    unique case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          state_d = ST_READ;
        end
      end
      // plain writes also complete here
      ST_READ: begin
        mem_en_o = 1'b1;
        mem_we_o = plain_wr;
        state_d  = req_q.amo ? ST_MODIFY : ST_RESP;
      end
      // old value is on the read port now
      ST_MODIFY: begin
        mem_en_o    = 1'b1;
        mem_we_o    = 1'b1;
        mem_wdata_o = mem_rdata_i + req_q.wdata;
        state_d     = ST_RESP;
      end
      ST_RESP: begin
        if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  // read port keeps the old value across the amo write
  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_o.rdata = plain_wr ? '0 : mem_rdata_i;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.id    = req_q.id;

endmodule

// ==== rtl/l2_mem.sv ====
module l2_mem (
  input  logic                        clk_i,
  input  logic                        en_i,
  input  logic                        we_i,
  input  pulp_pkg::l2_addr_t          addr_i,
  input  logic [pulp_pkg::DATA_W-1:0] wdata_i,
  output logic [pulp_pkg::DATA_W-1:0] rdata_o
);
  import pulp_pkg::*;

  logic [DATA_W-1:0] mem_q [L2_WORDS];

  // rdata only changes on a read, a write leaves it alone
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== rtl/pulp_pkg.sv ====
package pulp_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // cluster-local tag, widened by the cluster index on the bus
  localparam int unsigned TAG_W    = 3;
  localparam int unsigned CL_IDX_W = 1;
  localparam int unsigned ID_W     = TAG_W + CL_IDX_W;

  // L2 region in the address map
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h1C00_0000;
  localparam int unsigned L2_WORDS = 64;
  localparam int unsigned L2_IDX_W = $clog2(L2_WORDS);

  typedef logic [L2_IDX_W-1:0] l2_addr_t;

  // request as issued by a cluster
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic              amo;
    logic [TAG_W-1:0]  tag;
  } cl_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [TAG_W-1:0]  tag;
  } cl_rsp_t;

  // same request after widening, cluster index in the upper id bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic              amo;
    logic [ID_W-1:0]   id;
  } sb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [ID_W-1:0]   id;
  } sb_rsp_t;

endpackage
